//--- Bender.yml
package:
  name: map_switch

sources:
  - logic/game_pkg.sv
  - logic/video_pkg.sv
  - logic/level_select.sv
  - logic/menu_addr_gen.sv
  - logic/map_addr_gen.sv
  - logic/pixel_addr_mux.sv
  - logic/map_switch_top.sv
  - target: test
    files:
      - verif/map_switch_asserts.sv
      - verif/map_switch_tb.sv

//--- logic/game_pkg.sv
package game_pkg;

    // level number with a valid range of 1 to 5
    typedef logic [2:0] level_t;

    localparam level_t LEVEL_MIN = 3'd1;
    localparam level_t LEVEL_MAX = 3'd5;

    // decoded key vector
    localparam int KEY_W = 10;

    // two keys each for next and previous
    localparam int KEY_NEXT_A = 0;
    localparam int KEY_NEXT_B = 4;
    localparam int KEY_PREV_A = 2;
    localparam int KEY_PREV_B = 6;
    localparam int KEY_ENTER  = 8;

    typedef enum logic [1:0] {
        TILE_FLOOR = 2'd0,
        TILE_WALL  = 2'd1,
        TILE_BLOCK = 2'd2,
        TILE_GOAL  = 2'd3
    } tile_t;

    // layout rule for every level checks border, goal and blocks in that order
    function automatic tile_t tile_of(level_t level, logic [3:0] row, logic [4:0] col);
        logic [8:0] mix;
        mix = row * col + level;
        if (row == 4'd0 || row == 4'd14 || col == 5'd0 || col == 5'd19) begin
            return TILE_WALL;
        end
        if (row == 4'd13 && col == 5'd18) begin
            return TILE_GOAL;
        end
        // only the low two bits matter for modulo 4
        if (mix[1:0] == 2'b00) begin
            return TILE_BLOCK;
        end
        return TILE_FLOOR;
    endfunction

endpackage

//--- logic/level_select.sv
module level_select import game_pkg::*; (
    input  logic             clk,
    input  logic             rst,
    input  logic [KEY_W-1:0] key_down,
    output level_t           level,
    output logic             selected
);

    // set after each accepted move, cleared once all keys are up
    logic key_lock;
    logic any_key;
    logic next_press;
    logic prev_press;
    logic enter_press;
    logic can_act;

    assign any_key     = |key_down;
    assign next_press  = key_down[KEY_NEXT_A] | key_down[KEY_NEXT_B];
    assign prev_press  = key_down[KEY_PREV_A] | key_down[KEY_PREV_B];
    assign enter_press = key_down[KEY_ENTER];

    // menu only reacts before a level is confirmed
    assign can_act = !key_lock && !selected;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            level    <= LEVEL_MIN;
            selected <= 1'b0;
            key_lock <= 1'b1;
        end else if (!any_key) begin
            key_lock <= 1'b0;
        end else if (can_act) begin
            if (next_press) begin
                // clamp at the last level
                if (level < LEVEL_MAX) begin
                    level <= level + 3'd1;
                end
                key_lock <= 1'b1;
            end else if (prev_press) begin
                if (level > LEVEL_MIN) begin
                    level <= level - 3'd1;
                end
                key_lock <= 1'b1;
            end else if (enter_press) begin
                // sticky until reset
                selected <= 1'b1;
            end
        end
    end

endmodule

//--- logic/map_addr_gen.sv
module map_addr_gen import game_pkg::*, video_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  coord_t    vga_h,
    input  coord_t    vga_v,
    input  level_t    level,
    output pix_addr_t map_addr,
    output logic      map_active
);

    logic [8:0] img_x;
    logic [8:0] img_y;
    tile_row_t  tile_row;
    tile_col_t  tile_col;
    tile_off_t  off_x;
    tile_off_t  off_y;
    tile_t      kind;
    logic       active_d;
    pix_addr_t  addr_d;

    assign img_x = vga_h[9:1];
    assign img_y = vga_v[9:1];

    // tile grid position
    assign tile_row = tile_row_t'(img_y / TILE_PX);
    assign tile_col = tile_col_t'(img_x / TILE_PX);

    // pixel inside the tile
    assign off_x = tile_off_t'(img_x % TILE_PX);
    assign off_y = tile_off_t'(img_y % TILE_PX);

    assign kind = tile_of(level, tile_row, tile_col);

    assign active_d = (vga_h < H_ACTIVE) && (vga_v < V_ACTIVE);

    // each tile kind owns one block of words in the frame memory
    assign addr_d = pix_addr_t'(TILE_BASE + int'(kind) * TILE_WORDS +
                                int'(off_y) * TILE_PX + int'(off_x));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            map_active <= 1'b0;
        end else begin
            map_active <= active_d;
        end
    end

    always_ff @(posedge clk) begin
        map_addr <= addr_d;
    end

endmodule

//--- logic/map_switch_top.sv
module map_switch_top import game_pkg::*, video_pkg::*; (
    input  logic             clk,
    input  logic             rst,
    input  logic [KEY_W-1:0] key_down,
    input  coord_t           vga_h,
    input  coord_t           vga_v,
    output pix_addr_t        pixel_addr,
    output logic             pixel_valid,
    output level_t           level,
    output logic             selected
);

    pix_addr_t menu_addr;
    pix_addr_t map_addr;
    logic      menu_active;

    level_select level_select_i (
        .clk      (clk),
        .rst      (rst),
        .key_down (key_down),
        .level    (level),
        .selected (selected)
    );

    menu_addr_gen menu_addr_gen_i (
        .clk         (clk),
        .rst         (rst),
        .vga_h       (vga_h),
        .vga_v       (vga_v),
        .level       (level),
        .menu_addr   (menu_addr),
        .menu_active (menu_active)
    );

    // the menu side computes the same active test and feeds the mux
    map_addr_gen map_addr_gen_i (
        .clk        (clk),
        .rst        (rst),
        .vga_h      (vga_h),
        .vga_v      (vga_v),
        .level      (level),
        .map_addr   (map_addr),
        .map_active ()
    );

    pixel_addr_mux pixel_addr_mux_i (
        .clk         (clk),
        .rst         (rst),
        .selected    (selected),
        .menu_addr   (menu_addr),
        .map_addr    (map_addr),
        .active      (menu_active),
        .pixel_addr  (pixel_addr),
        .pixel_valid (pixel_valid)
    );

endmodule

//--- logic/menu_addr_gen.sv
module menu_addr_gen import game_pkg::*, video_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  coord_t    vga_h,
    input  coord_t    vga_v,
    input  level_t    level,
    output pix_addr_t menu_addr,
    output logic      menu_active
);

    logic [8:0] img_x;
    logic [8:0] img_y;
    logic [8:0] box_y0;
    logic       in_box;
    logic       active_d;
    pix_addr_t  addr_d;

    // half resolution image position
    assign img_x = vga_h[9:1];
    assign img_y = vga_v[9:1];

    // cursor moves down one step per level
    assign box_y0 = 9'(CURSOR_Y0 + (int'(level) - 1) * CURSOR_STEP);

    assign in_box = (img_x >= CURSOR_X0) && (img_x < CURSOR_X0 + CURSOR_PX) &&
                    (img_y >= box_y0) && (img_y < box_y0 + CURSOR_PX);

    assign active_d = (vga_h < H_ACTIVE) && (vga_v < V_ACTIVE);

    always_comb begin
        if (in_box) begin
            addr_d = pix_addr_t'(CURSOR_BASE + (img_y - box_y0) * CURSOR_PX +
                                 (img_x - CURSOR_X0));
        end else begin
            // off-screen rows may wrap and are blanked downstream
            addr_d = pix_addr_t'(MENU_BASE + img_y * IMG_W + img_x);
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            menu_active <= 1'b0;
        end else begin
            menu_active <= active_d;
        end
    end

    always_ff @(posedge clk) begin
        menu_addr <= addr_d;
    end

endmodule

//--- logic/pixel_addr_mux.sv
module pixel_addr_mux import video_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      selected,
    input  pix_addr_t menu_addr,
    input  pix_addr_t map_addr,
    input  logic      active,
    output pix_addr_t pixel_addr,
    output logic      pixel_valid
);

    pix_addr_t src_addr;

    // map once a level is confirmed, menu before that
    assign src_addr = selected ? map_addr : menu_addr;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pixel_addr  <= '0;
            pixel_valid <= 1'b0;
        end else if (!active) begin
            // outside the visible area
            pixel_addr  <= '0;
            pixel_valid <= 1'b0;
        end else begin
            pixel_addr  <= src_addr;
            pixel_valid <= 1'b1;
        end
    end

endmodule

//--- logic/video_pkg.sv
package video_pkg;

    typedef logic [9:0]  coord_t;
    typedef logic [16:0] pix_addr_t;

    localparam int H_ACTIVE = 640;
    localparam int V_ACTIVE = 480;

    // images are stored at half resolution
    localparam int IMG_W = 320;

    localparam int MENU_BASE = 0;

    // cursor sprite sits right after the menu picture
    localparam int CURSOR_BASE = 76800;
    localparam int CURSOR_X0   = 96;
    localparam int CURSOR_Y0   = 40;
    localparam int CURSOR_STEP = 32;
    localparam int CURSOR_PX   = 16;

    // four tile kinds of 16 by 16 words each
    localparam int TILE_BASE  = 77056;
    localparam int TILE_PX    = 16;
    localparam int TILE_WORDS = TILE_PX * TILE_PX;
    localparam int TILE_COLS  = 20;
    localparam int TILE_ROWS  = 15;

    typedef logic [$clog2(TILE_ROWS)-1:0] tile_row_t;
    typedef logic [$clog2(TILE_COLS)-1:0] tile_col_t;
    typedef logic [$clog2(TILE_PX)-1:0]   tile_off_t;

endpackage

//--- src.f
logic/game_pkg.sv
logic/video_pkg.sv
logic/level_select.sv
logic/menu_addr_gen.sv
logic/map_addr_gen.sv
logic/pixel_addr_mux.sv
logic/map_switch_top.sv
verif/map_switch_asserts.sv
verif/map_switch_tb.sv

//--- verif/map_switch_asserts.sv
module map_switch_asserts import game_pkg::*, video_pkg::*; (
    input logic      clk,
    input logic      rst,
    input level_t    level,
    input logic      selected,
    input pix_addr_t pixel_addr,
    input logic      pixel_valid
);

    // cursor never leaves the menu range
    level_in_range: assert property (
        @(posedge clk) disable iff (rst)
        (level >= LEVEL_MIN) && (level <= LEVEL_MAX)
    ) else $error("level %0d left the range 1 to 5", level);

    // blanked pixels carry a zero address
    blank_addr_zero: assert property (
        @(posedge clk) disable iff (rst)
        !pixel_valid |-> (pixel_addr == '0)
    ) else $error("pixel_addr %0d while pixel_valid is low", pixel_addr);

    // a confirmed level holds until reset
    selected_sticky: assert property (
        @(posedge clk) disable iff (rst)
        selected |=> selected
    ) else $error("selected fell without a reset");

    // pipeline is still empty right after reset
    valid_low_after_reset: assert property (
        @(posedge clk)
        $fell(rst) |-> !pixel_valid
    ) else $error("pixel_valid high in the first cycle after reset");

endmodule

bind map_switch_top map_switch_asserts asserts_i (
    .clk         (clk),
    .rst         (rst),
    .level       (level),
    .selected    (selected),
    .pixel_addr  (pixel_addr),
    .pixel_valid (pixel_valid)
);

//--- verif/map_switch_tb.sv
module map_switch_tb import game_pkg::*, video_pkg::*; ();

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 16;
    localparam int IDLE_CYCLES  = 3;
    localparam int MAX_HOLD     = 6;
    localparam int LATENCY      = 2;

    // decoded key vector layout
    localparam int NUM_KEYS   = 10;
    localparam int BIT_NEXT_A = 0;
    localparam int BIT_NEXT_B = 4;
    localparam int BIT_PREV_A = 2;
    localparam int BIT_PREV_B = 6;
    localparam int BIT_ENTER  = 8;

    // screen and frame memory geometry for the reference
    localparam int SCR_W      = 640;
    localparam int SCR_H      = 480;
    localparam int IMAGE_W    = 320;
    localparam int CUR_BASE   = 76800;
    localparam int CUR_X0     = 96;
    localparam int CUR_Y0     = 40;
    localparam int CUR_STEP   = 32;
    localparam int CUR_SIZE   = 16;
    localparam int TILES_BASE = 77056;
    localparam int TILE_SIZE  = 16;

    // coordinate stimulus kinds
    localparam int STIM_ACTIVE = 0;
    localparam int STIM_CURSOR = 1;
    localparam int STIM_BLANK  = 2;

    localparam int BOX_SAMPLES   = 40;
    localparam int MENU_SAMPLES  = 60;
    localparam int MAP_SAMPLES   = 80;
    localparam int BLANK_SAMPLES = 30;

    // run length budget for the watchdog
    localparam int PRESS_CYCLES   = MAX_HOLD + IDLE_CYCLES + 2;
    localparam int STREAM_EXTRA   = LATENCY + 2;
    localparam int NAV_CYCLES     = 16 * PRESS_CYCLES;
    localparam int MENU_CYCLES    = 5 * (PRESS_CYCLES + BOX_SAMPLES + MENU_SAMPLES
                                    + 2 * STREAM_EXTRA) + BLANK_SAMPLES + STREAM_EXTRA;
    localparam int CONFIRM_CYCLES = 5 * (RESET_CYCLES + 2 + 7 * PRESS_CYCLES
                                    + MAP_SAMPLES + BLANK_SAMPLES + 2 * STREAM_EXTRA);
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + 2 + NAV_CYCLES + MENU_CYCLES
                                    + CONFIRM_CYCLES + 200;

    logic                clk;
    logic                rst;
    logic [NUM_KEYS-1:0] key_down;
    coord_t              vga_h;
    coord_t              vga_v;
    pix_addr_t           pixel_addr;
    logic                pixel_valid;
    level_t              level;
    logic                selected;

    // expected menu state kept by the test sequence
    level_t      ref_level;
    logic        ref_selected;
    logic        compare_on;
    integer      seed;
    string       test_name;
    logic [17:0] exp_q[$];

    map_switch_top dut_i (
        .clk         (clk),
        .rst         (rst),
        .key_down    (key_down),
        .vga_h       (vga_h),
        .vga_v       (vga_v),
        .pixel_addr  (pixel_addr),
        .pixel_valid (pixel_valid),
        .level       (level),
        .selected    (selected)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // tile kind codes are floor 0, wall 1, block 2 and goal 3
    function automatic int ref_tile_kind(input int lvl, input int row, input int col);
        if (row == 0 || row == 14 || col == 0 || col == 19) begin
            return 1;
        end
        if (row == 13 && col == 18) begin
            return 3;
        end
        if ((row * col + lvl) % 4 == 0) begin
            return 2;
        end
        return 0;
    endfunction

    // valid flag sits above the address bits
    function automatic logic [17:0] expected_addr(input coord_t h, input coord_t v,
                                                  input level_t lvl, input logic sel);
        int ix;
        int iy;
        int box_y0;
        int kind;
        int addr;
        if (h >= SCR_W || v >= SCR_H) begin
            return 18'd0;
        end
        ix = int'(h) / 2;
        iy = int'(v) / 2;
        box_y0 = CUR_Y0 + (int'(lvl) - 1) * CUR_STEP;
        if (sel) begin
            kind = ref_tile_kind(int'(lvl), iy / TILE_SIZE, ix / TILE_SIZE);
            addr = TILES_BASE + kind * TILE_SIZE * TILE_SIZE
                   + (iy % TILE_SIZE) * TILE_SIZE + ix % TILE_SIZE;
        end else if (ix >= CUR_X0 && ix < CUR_X0 + CUR_SIZE &&
                     iy >= box_y0 && iy < box_y0 + CUR_SIZE) begin
            addr = CUR_BASE + (iy - box_y0) * CUR_SIZE + (ix - CUR_X0);
        end else begin
            addr = iy * IMAGE_W + ix;
        end
        return {1'b1, 17'(addr)};
    endfunction

    function automatic int rand_below(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    task automatic report_failure();
        $display("=== FAIL ===");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check_addr(input string what, input pix_addr_t expected,
                              input pix_addr_t actual);
        if (actual !== expected) begin
            $display("** Error [%s] %s: expected %0d, actual %0d",
                     test_name, what, expected, actual);
            report_failure();
        end
    endtask

    task automatic check_level(input string what, input level_t expected,
                               input level_t actual);
        if (actual !== expected) begin
            $display("** Error [%s] %s: expected %0d, actual %0d",
                     test_name, what, expected, actual);
            report_failure();
        end
    endtask

    task automatic check_flag(input string what, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("** Error [%s] %s: expected %b, actual %b",
                     test_name, what, expected, actual);
            report_failure();
        end
    endtask

    task automatic check_status();
        @(negedge clk);
        check_level("level", ref_level, level);
        check_flag("selected", ref_selected, selected);
    endtask

    task automatic check_after_reset();
        check_status();
        check_flag("pixel_valid", 1'b0, pixel_valid);
    endtask

    task automatic reset_dut();
        @(posedge clk);
        rst        <= 1'b1;
        key_down   <= '0;
        vga_h      <= '0;
        vga_v      <= '0;
        compare_on = 1'b0;
        ref_level    = 3'd1;
        ref_selected = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
    endtask

    task automatic press_key(input int key_bit, input int hold);
        logic [NUM_KEYS-1:0] keys;
        keys = '0;
        keys[key_bit] = 1'b1;
        @(posedge clk);
        key_down <= keys;
        repeat (hold) @(posedge clk);
        key_down <= '0;
        repeat (IDLE_CYCLES) @(posedge clk);
    endtask

    // one press moves at most one clamped step and only before confirm
    task automatic move_level(input int key_bit, input int hold, input int dir);
        press_key(key_bit, hold);
        if (!ref_selected) begin
            if (dir > 0 && ref_level < 3'd5) begin
                ref_level = ref_level + 3'd1;
            end else if (dir < 0 && ref_level > 3'd1) begin
                ref_level = ref_level - 3'd1;
            end
        end
        check_status();
    endtask

    task automatic confirm_level();
        press_key(BIT_ENTER, 2);
        ref_selected = 1'b1;
        check_status();
    endtask

    task automatic pick_coords(input int kind, output coord_t h, output coord_t v);
        int box_y0;
        int ix;
        int iy;
        case (kind)
            STIM_ACTIVE: begin
                h = coord_t'(rand_below(SCR_W));
                v = coord_t'(rand_below(SCR_H));
            end
            STIM_CURSOR: begin
                // box of the current level plus a two pixel rim
                box_y0 = CUR_Y0 + (int'(ref_level) - 1) * CUR_STEP;
                ix = CUR_X0 - 2 + rand_below(CUR_SIZE + 4);
                iy = box_y0 - 2 + rand_below(CUR_SIZE + 4);
                h = coord_t'(ix * 2 + rand_below(2));
                v = coord_t'(iy * 2 + rand_below(2));
            end
            default: begin
                if (rand_below(2) == 1) begin
                    h = coord_t'(SCR_W + rand_below(1024 - SCR_W));
                    v = coord_t'(rand_below(1024));
                end else begin
                    h = coord_t'(rand_below(1024));
                    v = coord_t'(SCR_H + rand_below(1024 - SCR_H));
                end
            end
        endcase
    endtask

    task automatic stream_coords(input int count, input int kind);
        coord_t h;
        coord_t v;
        for (int i = 0; i < count; i++) begin
            pick_coords(kind, h, v);
            @(posedge clk);
            vga_h <= h;
            vga_v <= v;
            compare_on = 1'b1;
        end
        // let the last pair drain through the pipeline
        repeat (LATENCY + 1) @(posedge clk);
        compare_on = 1'b0;
    endtask

    // expected values wait LATENCY cycles for the registered outputs
    always @(negedge clk) begin
        logic [17:0] expected;
        if (!compare_on) begin
            exp_q.delete();
        end else begin
            exp_q.push_back(expected_addr(vga_h, vga_v, ref_level, ref_selected));
            if (exp_q.size() > LATENCY) begin
                expected = exp_q.pop_front();
                check_flag("pixel_valid", expected[17], pixel_valid);
                check_addr("pixel_addr", expected[16:0], pixel_addr);
            end
        end
    end

    initial begin
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        $display("timeout: tests still running after %0d cycles", TIMEOUT_CYCLES);
        $display("=== FAIL ===");
        $fatal(1, "watchdog expired");
    end

    initial begin
        clk          = 1'b0;
        rst          = 1'b1;
        key_down     = '0;
        vga_h        = '0;
        vga_v        = '0;
        compare_on   = 1'b0;
        seed         = 32'h578d;
        ref_level    = 3'd1;
        ref_selected = 1'b0;

        test_name = "reset";
        reset_dut();
        check_after_reset();

        test_name = "navigation";
        move_level(BIT_NEXT_A, MAX_HOLD, 1);
        for (int i = 0; i < 5; i++) begin
            move_level((i % 2 == 0) ? BIT_NEXT_B : BIT_NEXT_A, 2, 1);
        end
        for (int i = 0; i < 6; i++) begin
            move_level((i % 2 == 0) ? BIT_PREV_A : BIT_PREV_B, 1 + i % 3, -1);
        end

        test_name = "menu";
        for (int lvl = 1; lvl <= 5; lvl++) begin
            if (lvl > 1) begin
                move_level(BIT_NEXT_B, 1, 1);
            end
            stream_coords(BOX_SAMPLES, STIM_CURSOR);
            stream_coords(MENU_SAMPLES, STIM_ACTIVE);
        end

        test_name = "menu blanking";
        stream_coords(BLANK_SAMPLES, STIM_BLANK);

        for (int lvl = 1; lvl <= 5; lvl++) begin
            test_name = $sformatf("confirm level %0d", lvl);
            reset_dut();
            check_after_reset();
            for (int i = 1; i < lvl; i++) begin
                move_level(BIT_NEXT_A, 1, 1);
            end
            confirm_level();
            stream_coords(MAP_SAMPLES, STIM_ACTIVE);
            // level is frozen after confirm
            move_level(BIT_NEXT_B, 2, 1);
            move_level(BIT_PREV_A, 2, -1);
            stream_coords(BLANK_SAMPLES, STIM_BLANK);
        end

        $display("=== PASS ===");
        $finish;
    end

endmodule
